//--- design/mem_test_pkg.sv
package mem_test_pkg;

	// One memory data word.
	typedef logic [15:0] word_t;

	// Memory word address.
	typedef logic [23:0] addr_t;

	// Words per read burst, also the buffer FIFO depth.
	localparam int BURST = 4;

	// First word of the tested region.
	localparam int BASE = 16;

	// Words in the tested region, a multiple of BURST.
	localparam int SIZE = 32;

	// Memory model depth, at least BASE + SIZE.
	localparam int MEM_WORDS = 64;

	// Cycles from a seen request to its acknowledge.
	localparam int ACK_LAT = 2;

	// Rate limit counter width, gives an eight cycle gap.
	localparam int GAP_BITS = 3;

	// Tester sequencing.
	typedef enum logic [2:0] {
		st_write_wait,
		st_write,
		st_read_wait,
		st_read,
		st_receive,
		st_verify_wait,
		st_verify
	} test_state_t;

endpackage

//--- design/mem_test_fifo.sv
`timescale 1ns/1ps

module mem_test_fifo #(
	parameter int DEPTH = mem_test_pkg::BURST
) (
	input logic clkSYS,
	input logic n_reset,

	input mem_test_pkg::word_t wdata,
	input logic push,
	input logic pop,

	output mem_test_pkg::word_t rdata,
	output logic empty,
	output logic full
);

	mem_test_pkg::word_t buffer [DEPTH];

	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;

	logic do_push;
	logic do_pop;

	assign empty = count == '0;
	assign full = count == ($clog2(DEPTH+1))'(DEPTH);

	// Writes into a full buffer and reads from an empty one are dropped.
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge clkSYS) begin
		if (do_push)
			buffer[wr_ptr] <= wdata;
		if (do_pop)
			rdata <= buffer[rd_ptr];
	end

	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				if (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				if (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			// Occupancy only moves when exactly one side acts.
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

//--- design/mem_test.sv
`timescale 1ns/1ps

module mem_test #(
	parameter int BURST = mem_test_pkg::BURST,
	parameter int BASE = mem_test_pkg::BASE,
	parameter int SIZE = mem_test_pkg::SIZE
) (
	input logic clkSYS,
	input logic n_reset,

	input mem_test_pkg::word_t rdata,
	input logic rvalid,

	output mem_test_pkg::addr_t addr,
	output mem_test_pkg::word_t data,
	output logic req,
	output logic wr,
	input logic ack,

	output logic fail,
	input logic enable,
	input logic clear,
	input logic pattern
);

	mem_test_pkg::test_state_t state;

	logic pop;
	logic empty;
	logic full;
	mem_test_pkg::word_t fifo_q;

	logic [32:0] seed_lfsr;

	logic reload;
	logic [mem_test_pkg::GAP_BITS-1:0] gap_cnt;
	logic gap_done;

	logic advance;
	logic frame;
	mem_test_pkg::addr_t acnt;
	mem_test_pkg::addr_t acnt_next;

	logic seed_update;
	logic seed_reload;
	logic [17:0] pat;
	logic [17:0] pat_next;
	logic [17:0] pat_seed;

	logic check;
	logic mismatch;

	// Read bursts collect here until checked.
	mem_test_fifo #(
		.DEPTH (BURST)
	) i_fifo (
		.clkSYS  (clkSYS),
		.n_reset (n_reset),
		.wdata   (rdata),
		.push    (rvalid),
		.pop     (pop),
		.rdata   (fifo_q),
		.empty   (empty),
		.full    (full)
	);

	// Free running seed source, taps 33 and 20.
	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset)
			seed_lfsr <= 33'd1;
		else
			seed_lfsr <= {seed_lfsr[31:0], seed_lfsr[32] ^ seed_lfsr[19]};
	end

	// Gap counter, restarted during every active state.
	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			gap_cnt <= '0;
			gap_done <= 1'b0;
		end else if (reload) begin
			gap_cnt <= '0;
			gap_done <= 1'b0;
		end else begin
			gap_cnt <= gap_cnt + 1'b1;
			gap_done <= gap_cnt == '1;
		end
	end

	// Word index within the region.
	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			acnt <= '0;
			acnt_next <= '0;
			frame <= 1'b0;
		end else begin
			if (advance)
				acnt <= acnt_next;
			if (acnt == mem_test_pkg::addr_t'(SIZE - 1)) begin
				acnt_next <= '0;
				frame <= 1'b1;
			end else begin
				acnt_next <= acnt + 1'b1;
				frame <= 1'b0;
			end
		end
	end

	always_ff @(posedge clkSYS)
		addr <= mem_test_pkg::addr_t'(BASE) + acnt;

	// Inverted shift keeps the all-zero start from locking up.
	always_ff @(posedge clkSYS)
		pat_next <= ~{pat[16:0], pat[17] ^ pat[10]};

	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			data <= '0;
			pat <= '0;
			pat_seed <= '0;
		end else if (seed_update) begin
			data <= seed_lfsr[15:0];
			pat <= seed_lfsr[17:0];
			pat_seed <= seed_lfsr[17:0];
		end else if (seed_reload) begin
			data <= pat_seed[15:0];
			pat <= pat_seed;
		end else if (advance && pattern) begin
			data <= pat_next[15:0];
			pat <= pat_next;
		end
	end

	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			state <= mem_test_pkg::st_write_wait;
		end else begin
			case (state)
			mem_test_pkg::st_write_wait:
				if (gap_done)
					state <= mem_test_pkg::st_write;
			mem_test_pkg::st_write:
				if (ack)
					state <= frame ? mem_test_pkg::st_read_wait : mem_test_pkg::st_write_wait;
			mem_test_pkg::st_read_wait:
				if (gap_done)
					state <= mem_test_pkg::st_read;
			mem_test_pkg::st_read:
				if (ack)
					state <= mem_test_pkg::st_receive;
			mem_test_pkg::st_receive:
				if (full)
					state <= mem_test_pkg::st_verify_wait;
			mem_test_pkg::st_verify_wait:
				if (gap_done)
					state <= mem_test_pkg::st_verify;
			mem_test_pkg::st_verify:
				if (!empty)
					state <= mem_test_pkg::st_verify_wait;
				else if (frame)
					state <= mem_test_pkg::st_write_wait;
				else
					state <= mem_test_pkg::st_read_wait;
			default:
				state <= mem_test_pkg::st_write_wait;
			endcase
		end
	end

	// Strobes follow the state by one cycle.
	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			advance <= 1'b0;
			reload <= 1'b0;
			seed_reload <= 1'b0;
			seed_update <= 1'b0;
		end else begin
			advance <= (state == mem_test_pkg::st_write && ack) ||
				state == mem_test_pkg::st_verify;
			reload <= state != mem_test_pkg::st_write_wait &&
				state != mem_test_pkg::st_read_wait &&
				state != mem_test_pkg::st_verify_wait;
			seed_reload <= state == mem_test_pkg::st_write && ack && frame;
			seed_update <= state == mem_test_pkg::st_verify && empty && frame;
		end
	end

	// A raised request is held until its acknowledge.
	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			req <= 1'b0;
			wr <= 1'b0;
		end else if (state == mem_test_pkg::st_write || state == mem_test_pkg::st_read) begin
			wr <= state == mem_test_pkg::st_write;
			if (ack)
				req <= 1'b0;
			else if (!req)
				req <= enable;
		end else begin
			req <= 1'b0;
		end
	end

	assign pop = state == mem_test_pkg::st_verify_wait && gap_done;

	// Popped word meets its expected value two cycles after the pop.
	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			check <= 1'b0;
			mismatch <= 1'b0;
		end else begin
			check <= state == mem_test_pkg::st_verify;
			mismatch <= check && (fifo_q != data);
		end
	end

	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset)
			fail <= 1'b0;
		else if (clear)
			fail <= 1'b0;
		else if (mismatch)
			fail <= 1'b1;
	end

endmodule

//--- design/burst_sram.sv
`timescale 1ns/1ps

module burst_sram #(
	parameter int MEM_WORDS = mem_test_pkg::MEM_WORDS,
	parameter int ACK_LAT = mem_test_pkg::ACK_LAT
) (
	input logic clkSYS,
	input logic n_reset,

	input mem_test_pkg::addr_t addr,
	input mem_test_pkg::word_t wdata,
	input logic req,
	input logic wr,
	output logic ack,

	output mem_test_pkg::word_t rdata,
	output logic rvalid,

	input mem_test_pkg::word_t stuck_mask
);

	mem_test_pkg::word_t mem [MEM_WORDS];

	logic [$clog2(MEM_WORDS)-1:0] req_idx;
	logic [$clog2(MEM_WORDS)-1:0] burst_idx;
	logic [$clog2(mem_test_pkg::BURST+1)-1:0] burst_left;

	logic [$clog2(ACK_LAT+1)-1:0] lat_cnt;
	logic done;

	assign req_idx = addr[$clog2(MEM_WORDS)-1:0];

	// One acknowledge per request, then wait for req to drop.
	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			lat_cnt <= '0;
			done <= 1'b0;
			ack <= 1'b0;
		end else if (!req) begin
			lat_cnt <= '0;
			done <= 1'b0;
			ack <= 1'b0;
		end else if (!done && lat_cnt == ($clog2(ACK_LAT+1))'(ACK_LAT - 1)) begin
			lat_cnt <= '0;
			done <= 1'b1;
			ack <= 1'b1;
		end else begin
			if (!done)
				lat_cnt <= lat_cnt + 1'b1;
			ack <= 1'b0;
		end
	end

	// Writes land in the acknowledge cycle.
	always_ff @(posedge clkSYS) begin
		if (ack && wr)
			mem[req_idx] <= wdata;
	end

	// Set mask bits read back as one, like a shorted data line.
	always_ff @(posedge clkSYS) begin
		if (ack && !wr)
			rdata <= mem[req_idx] | stuck_mask;
		else if (burst_left != '0)
			rdata <= mem[burst_idx] | stuck_mask;
	end

	// First burst word follows the acknowledge, the rest stream behind it.
	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			rvalid <= 1'b0;
			burst_idx <= '0;
			burst_left <= '0;
		end else if (ack && !wr) begin
			rvalid <= 1'b1;
			burst_idx <= req_idx + 1'b1;
			burst_left <= ($clog2(mem_test_pkg::BURST+1))'(mem_test_pkg::BURST - 1);
		end else if (burst_left != '0) begin
			rvalid <= 1'b1;
			burst_idx <= burst_idx + 1'b1;
			burst_left <= burst_left - 1'b1;
		end else begin
			rvalid <= 1'b0;
		end
	end

endmodule

//--- design/mem_test_top.sv
`timescale 1ns/1ps

module mem_test_top (
	input logic clkSYS,
	input logic n_reset,

	input logic enable,
	input logic clear,
	input logic pattern,
	input mem_test_pkg::word_t stuck_mask,

	output logic fail,
	output mem_test_pkg::addr_t addr,
	output logic wr,
	output logic req,
	output logic ack
);

	mem_test_pkg::word_t wdata;
	mem_test_pkg::word_t rdata;
	logic rvalid;

	// Pattern generator and checker.
	mem_test #(
		.BURST (mem_test_pkg::BURST),
		.BASE  (mem_test_pkg::BASE),
		.SIZE  (mem_test_pkg::SIZE)
	) i_mem_test (
		.clkSYS  (clkSYS),
		.n_reset (n_reset),
		.rdata   (rdata),
		.rvalid  (rvalid),
		.addr    (addr),
		.data    (wdata),
		.req     (req),
		.wr      (wr),
		.ack     (ack),
		.fail    (fail),
		.enable  (enable),
		.clear   (clear),
		.pattern (pattern)
	);

	// Memory under test.
	burst_sram #(
		.MEM_WORDS (mem_test_pkg::MEM_WORDS),
		.ACK_LAT   (mem_test_pkg::ACK_LAT)
	) i_burst_sram (
		.clkSYS     (clkSYS),
		.n_reset    (n_reset),
		.addr       (addr),
		.wdata      (wdata),
		.req        (req),
		.wr         (wr),
		.ack        (ack),
		.rdata      (rdata),
		.rvalid     (rvalid),
		.stuck_mask (stuck_mask)
	);

endmodule

//--- verification/mem_test_properties.sv
`timescale 1ns/1ps

module mem_test_properties (
	input logic clkSYS,
	input logic n_reset,
	input logic req,
	input logic ack,
	input logic fail,
	input logic clear,
	input mem_test_pkg::addr_t addr
);

	// The request drops on the cycle after its acknowledge.
	req_drops_after_ack: assert property (
		@(posedge clkSYS) disable iff (!n_reset)
		ack |=> !req
	) else $error("req still high the cycle after ack");

	ack_needs_req: assert property (
		@(posedge clkSYS) disable iff (!n_reset)
		ack |-> req
	) else $error("ack without a pending req");

	// Sticky until clear.
	fail_is_sticky: assert property (
		@(posedge clkSYS) disable iff (!n_reset)
		fail && !clear |=> fail
	) else $error("fail dropped without clear");

	addr_in_region: assert property (
		@(posedge clkSYS) disable iff (!n_reset)
		req |-> (addr >= mem_test_pkg::addr_t'(mem_test_pkg::BASE) &&
			addr <= mem_test_pkg::addr_t'(mem_test_pkg::BASE + mem_test_pkg::SIZE - 1))
	) else $error("request address outside the tested region");

endmodule

//--- verification/mem_test_tb.sv
`timescale 1ns/1ps

module mem_test_tb;

	logic clkSYS;
	logic n_reset;
	logic enable;
	logic clear;
	logic pattern;
	mem_test_pkg::word_t stuck_mask;
	logic fail;
	mem_test_pkg::addr_t addr;
	logic wr;
	logic req;
	logic ack;

	int errors;
	int tests_run;
	int tests_failed;
	int seed;
	int frames_done;
	int ack_wait;
	logic req_q;
	logic last_read;
	mem_test_pkg::addr_t write_log [$];

	mem_test_top i_dut (.*);

	bind mem_test mem_test_properties i_mem_test_properties (
		.clkSYS, .n_reset, .req, .ack, .fail, .clear, .addr
	);

	// One read burst with its verify steps, rounded up.
	function automatic int burst_cycles();
		return 24 + mem_test_pkg::BURST * 12;
	endfunction

	// Each word write costs the gap plus the handshake.
	function automatic int frame_cycles();
		return mem_test_pkg::SIZE * 16 +
			(mem_test_pkg::SIZE / mem_test_pkg::BURST) * burst_cycles();
	endfunction

	initial begin
		clkSYS = 1'b0;
		forever #50 clkSYS = ~clkSYS;
	end

	// Five tests, three frames each.
	initial begin
		repeat (5 * 3 * frame_cycles()) @(posedge clkSYS);
		$display("watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	// A write request that follows a read request starts a new frame.
	always @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			req_q <= 1'b0;
			last_read <= 1'b0;
			frames_done <= 0;
			ack_wait <= 0;
		end else begin
			req_q <= req;
			if (req && !req_q) begin
				ack_wait <= 1;
				last_read <= !wr;
				if (wr && last_read)
					frames_done <= frames_done + 1;
				if (wr)
					write_log.push_back(addr);
			end else if (req && !ack) begin
				ack_wait <= ack_wait + 1;
			end
			// Every acknowledge comes ACK_LAT cycles after the memory first sees req.
			if (ack && ack_wait != mem_test_pkg::ACK_LAT)
				report_mismatch("ack latency", ack_wait, mem_test_pkg::ACK_LAT);
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
		errors++;
	endtask

	task automatic apply_reset();
		@(negedge clkSYS);
		n_reset = 1'b0;
		repeat (10) @(negedge clkSYS);
		n_reset = 1'b1;
	endtask

	task automatic wait_frames(input int count);
		int target;
		int cycles;
		target = frames_done + count;
		cycles = 0;
		while (frames_done < target && cycles < (count + 1) * frame_cycles()) begin
			@(negedge clkSYS);
			cycles++;
		end
		if (frames_done < target) begin
			$display("no frame end seen within %0d cycles", cycles);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("%s: pass", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - start_errors);
		end
	endtask

	task automatic test_clean_lfsr();
		int start_errors;
		int i;
		start_errors = errors;
		pattern = 1'b1;
		enable = 1'b1;
		apply_reset();
		write_log.delete();
		wait_frames(2);
		if (fail !== 1'b0)
			report_mismatch("fail", 32'(fail), 32'd0);
		if (write_log.size() < 2 * mem_test_pkg::SIZE)
			report_mismatch("write count", write_log.size(), 2 * mem_test_pkg::SIZE);
		// Each frame walks the region upward from its base.
		for (i = 0; i < 2 * mem_test_pkg::SIZE && i < write_log.size(); i++) begin
			if (write_log[i] !== mem_test_pkg::BASE + i % mem_test_pkg::SIZE)
				report_mismatch("addr", 32'(write_log[i]),
					mem_test_pkg::BASE + i % mem_test_pkg::SIZE);
		end
		finish_test("clean_lfsr", start_errors);
	endtask

	task automatic test_clean_const();
		int start_errors;
		start_errors = errors;
		pattern = 1'b0;
		enable = 1'b1;
		apply_reset();
		write_log.delete();
		wait_frames(2);
		if (fail !== 1'b0)
			report_mismatch("fail", 32'(fail), 32'd0);
		// Two whole frames plus the first write of the third.
		if (write_log.size() != 2 * mem_test_pkg::SIZE + 1)
			report_mismatch("write count", write_log.size(), 2 * mem_test_pkg::SIZE + 1);
		finish_test("clean_const", start_errors);
	endtask

	task automatic test_fault_detect();
		int start_errors;
		int cycles;
		start_errors = errors;
		pattern = 1'b1;
		enable = 1'b1;
		stuck_mask = mem_test_pkg::word_t'($random(seed));
		if (stuck_mask == '0)
			stuck_mask = 16'h0001;
		apply_reset();
		cycles = 0;
		while (fail !== 1'b1 && frames_done == 0 && cycles < frame_cycles()) begin
			@(negedge clkSYS);
			cycles++;
		end
		if (fail !== 1'b1)
			report_mismatch("fail", 32'(fail), 32'd1);
		if (frames_done != 0) begin
			$display("fail rose only after the first read-back pass had ended");
			errors++;
		end
		finish_test("fault_detect", start_errors);
	endtask

	task automatic test_sticky_clear();
		int start_errors;
		start_errors = errors;
		wait_frames(1);
		if (fail !== 1'b1)
			report_mismatch("fail", 32'(fail), 32'd1);
		stuck_mask = '0;
		wait_frames(1);
		if (fail !== 1'b1)
			report_mismatch("fail", 32'(fail), 32'd1);
		clear = 1'b1;
		@(negedge clkSYS);
		clear = 1'b0;
		if (fail !== 1'b0)
			report_mismatch("fail", 32'(fail), 32'd0);
		wait_frames(1);
		if (fail !== 1'b0)
			report_mismatch("fail", 32'(fail), 32'd0);
		finish_test("sticky_clear", start_errors);
	endtask

	task automatic test_stall();
		int start_errors;
		mem_test_pkg::addr_t held;
		start_errors = errors;
		enable = 1'b0;
		// Verify steps keep going until the tester reaches a request state.
		repeat (2 * burst_cycles()) @(negedge clkSYS);
		held = addr;
		repeat (50) begin
			@(negedge clkSYS);
			if (req !== 1'b0)
				report_mismatch("req", 32'(req), 32'd0);
			if (addr !== held)
				report_mismatch("addr", 32'(addr), 32'(held));
		end
		enable = 1'b1;
		wait_frames(2);
		if (fail !== 1'b0)
			report_mismatch("fail", 32'(fail), 32'd0);
		finish_test("stall", start_errors);
	endtask

	initial begin
		seed = 32'hdd39_6559;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		n_reset = 1'b0;
		enable = 1'b0;
		clear = 1'b0;
		pattern = 1'b0;
		stuck_mask = '0;
		test_clean_lfsr();
		test_clean_const();
		test_fault_detect();
		test_sticky_clear();
		test_stall();
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- sim.f
design/mem_test_pkg.sv
design/mem_test_fifo.sv
design/mem_test.sv
design/burst_sram.sv
design/mem_test_top.sv
verification/mem_test_properties.sv
verification/mem_test_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module mem_test_tb -f sim.f
	@out="$$(./obj_dir/Vmem_test_tb)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
